/* tb.f */
+incdir+design
design/motor_pkg.sv
design/pwm_pkg.sv
design/motor_rate_if.sv
design/motor_cmd_regs.sv
design/pwm_generator_block.sv
design/pwm_generator.sv
design/motor_output_top.sv
verif/pwm_checker.sv
verif/tb_motor_output.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the motor output stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_motor_output -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "Result: PASSED"; then
	exit 0
fi
exit 1

/* verif/tb_motor_output.sv */
/*
 * Testbench for the motor output stage
 * Clock, reset, LCG stimulus, command driver, watchdog, report
 */
`timescale 1ns/1ps
`include "drone_pwm_cfg.svh"

module tb_motor_output
	import motor_pkg::*;
();

	localparam int CLK_NS     = 8;
	// Cycles motor 1 must be high before a command goes out
	localparam int LEAD       = 4;
	localparam int PERIOD_NS  = (`PWM_PERIOD_US + 1) * CLK_NS;
	// 40 frames of test plus reset and slack
	localparam int TIMEOUT_NS = 40 * PERIOD_NS + 200 * CLK_NS;

	logic        us_clk;
	logic        resetn;
	logic        cmd_valid;
	logic        cmd_ready;
	motor_op_e   cmd_op;
	motor_id_t   cmd_motor;
	motor_rate_t cmd_rate;
	logic        motor_1_pwm;
	logic        motor_2_pwm;
	logic        motor_3_pwm;
	logic        motor_4_pwm;
	logic [31:0] lcg_state;
	int          chk_errors;
	int          accept_count;
	int          pulse_count;
	int          drv_errors;
	int          sent;

	motor_output_top uut (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_op      (cmd_op),
		.cmd_motor   (cmd_motor),
		.cmd_rate    (cmd_rate),
		.motor_1_pwm (motor_1_pwm),
		.motor_2_pwm (motor_2_pwm),
		.motor_3_pwm (motor_3_pwm),
		.motor_4_pwm (motor_4_pwm)
	);

	pwm_checker u_checker (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.cmd_valid    (cmd_valid),
		.cmd_ready    (cmd_ready),
		.cmd_op       (cmd_op),
		.cmd_motor    (cmd_motor),
		.cmd_rate     (cmd_rate),
		.pwm          ({motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm}),
		.error_count  (chk_errors),
		.accept_count (accept_count),
		.pulse_count  (pulse_count)
	);

	initial us_clk = 1'b0;
	always #(CLK_NS / 2) us_clk = ~us_clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Sends one command inside a high pulse
	// Held until accepted
	task automatic send_cmd(input motor_op_e op, input motor_id_t mot,
		input motor_rate_t rate, output int stall);
		int   run;
		logic ready_now;
		run   = 0;
		stall = 0;
		while (run < LEAD) begin
			@(posedge us_clk);
			#1;
			run = motor_1_pwm ? run + 1 : 0;
		end
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_motor = mot;
		cmd_rate  = rate;
		// Ready depends on state only
		// Stable until the next edge
		do begin
			ready_now = cmd_ready;
			@(posedge us_clk);
			#1;
			if (!ready_now)
				stall++;
		end while (!ready_now);
		cmd_valid = 1'b0;
		sent++;
	endtask

	// Frame pacing on motor 1 rising edges
	task automatic wait_pulses(input int n);
		int   rises;
		logic last;
		rises = 0;
		last  = motor_1_pwm;
		while (rises < n) begin
			@(posedge us_clk);
			#1;
			if (motor_1_pwm && !last)
				rises++;
			last = motor_1_pwm;
		end
	endtask

	initial begin
		motor_rate_t rate;
		int          stall;
		lcg_state  = 32'd54038;
		cmd_valid  = 1'b0;
		cmd_op     = OP_SET_RATE;
		cmd_motor  = '0;
		cmd_rate   = '0;
		drv_errors = 0;
		sent       = 0;
		resetn     = 1'b0;
		repeat (8) @(posedge us_clk);
		#1;
		resetn = 1'b1;

		// Zero-rate pulses while disarmed
		wait_pulses(3);

		// Rates stored while disarmed show only once armed
		for (int i = 0; i < `NUM_MOTORS; i++) begin
			lcg_state = lcg_next(lcg_state);
			send_cmd(OP_SET_RATE, motor_id_t'(i), lcg_state[23:16], stall);
		end
		wait_pulses(2);
		send_cmd(OP_ARM, '0, '0, stall);
		wait_pulses(3);

		// Random rates to random motors
		// Now and then a repeated ARM
		for (int i = 0; i < 8; i++) begin
			lcg_state = lcg_next(lcg_state);
			send_cmd(OP_SET_RATE, lcg_state[29:28], lcg_state[23:16], stall);
			if (lcg_state[31])
				send_cmd(OP_ARM, '0, '0, stall);
			wait_pulses(1);
		end

		// Rate extremes swapped between motor pairs
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < `NUM_MOTORS; i++) begin
				rate = ((i + pass) % 2 == 0) ? '1 : '0;
				send_cmd(OP_SET_RATE, motor_id_t'(i), rate, stall);
			end
			wait_pulses(2);
		end

		// Disarm clears the rates
		// Re-arm comes back at zero
		send_cmd(OP_DISARM, '0, '0, stall);
		wait_pulses(2);
		send_cmd(OP_ARM, '0, '0, stall);
		wait_pulses(2);

		// Valid held through the whole hold
		send_cmd(OP_DISARM, '0, '0, stall);
		wait_pulses(1);
		send_cmd(OP_ARM, '0, '0, stall);
		lcg_state = lcg_next(lcg_state);
		send_cmd(OP_SET_RATE, lcg_state[29:28], lcg_state[23:16], stall);
		if (stall != `ARM_HOLD_CYCLES - LEAD) begin
			drv_errors++;
			$display("[ERROR] %0t: held command stalled %0d cycles, expected %0d",
				$time, stall, `ARM_HOLD_CYCLES - LEAD);
		end
		wait_pulses(3);

		if (accept_count != sent) begin
			drv_errors++;
			$display("[ERROR] %0t: DUT accepted %0d commands, driver sent %0d",
				$time, accept_count, sent);
		end
		if (pulse_count == 0) begin
			drv_errors++;
			$display("No pulse was measured during the run");
		end
		$display("Checker errors: %0d, driver errors: %0d, pulses checked: %0d",
			chk_errors, drv_errors, pulse_count);
		if (chk_errors + drv_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog: run timed out at %0t before the tests finished", $time);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* verif/pwm_checker.sv */
/*
 * Scoreboard for the motor output stage
 * Models arming and rates, measures pulse widths and periods
 */
`timescale 1ns/1ps
`include "drone_pwm_cfg.svh"

module pwm_checker
	import motor_pkg::*;
(
	input  logic                   us_clk,
	input  logic                   resetn,
	input  logic                   cmd_valid,
	input  logic                   cmd_ready,
	input  motor_op_e              cmd_op,
	input  motor_id_t              cmd_motor,
	input  motor_rate_t            cmd_rate,
	input  logic [`NUM_MOTORS-1:0] pwm,
	output int                     error_count,
	output int                     accept_count,
	output int                     pulse_count
);

	localparam int PERIOD = `PWM_PERIOD_US + 1;

	arm_state_e             st;
	int                     hold_left;
	int                     ready_low;
	motor_rate_t            rate_m [`NUM_MOTORS];
	// Rate bus contents one and two cycles back
	motor_rate_t            eff_d1 [`NUM_MOTORS];
	motor_rate_t            eff_d2 [`NUM_MOTORS];
	logic [`NUM_MOTORS-1:0] pwm_q;
	logic [`NUM_MOTORS-1:0] seen;
	int                     since_rise [`NUM_MOTORS];
	int                     high_len [`NUM_MOTORS];
	int                     exp_w [`NUM_MOTORS];

	task automatic report_error(input string msg);
		error_count++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	// Sampled mid-cycle, model holds the state after the last rising edge
	always @(negedge us_clk or negedge resetn) begin
		if (!resetn) begin
			st           = ST_DISARMED;
			hold_left    = 0;
			ready_low    = 0;
			pwm_q        = '0;
			seen         = '0;
			error_count  = 0;
			accept_count = 0;
			pulse_count  = 0;
			for (int m = 0; m < `NUM_MOTORS; m++) begin
				rate_m[m]     = '0;
				eff_d1[m]     = '0;
				eff_d2[m]     = '0;
				since_rise[m] = 0;
				high_len[m]   = 0;
				exp_w[m]      = 0;
			end
		end else begin
			// Ready only drops in the arming hold
			if (cmd_ready !== (st != ST_ARMING))
				report_error($sformatf("cmd_ready is %b in state %s", cmd_ready, st.name()));
			if (!cmd_ready) begin
				ready_low++;
			end else begin
				if (ready_low != 0 && ready_low != `ARM_HOLD_CYCLES)
					report_error($sformatf("ready low for %0d cycles, expected %0d",
						ready_low, `ARM_HOLD_CYCLES));
				ready_low = 0;
			end
			for (int m = 0; m < `NUM_MOTORS; m++) begin
				since_rise[m]++;
				if (pwm[m] && !pwm_q[m]) begin
					// First frame after reset stays low
					if (seen[m] && since_rise[m] != PERIOD)
						report_error($sformatf("motor %0d period %0d cycles, expected %0d",
							m + 1, since_rise[m], PERIOD));
					else if (!seen[m] && (since_rise[m] < PERIOD || since_rise[m] > PERIOD + 2))
						report_error($sformatf("motor %0d first pulse after %0d cycles",
							m + 1, since_rise[m]));
					seen[m]       = 1'b1;
					since_rise[m] = 0;
					high_len[m]   = 1;
					// Rate latched at the wrap edge before the rise
					exp_w[m]      = `MIN_PWM_TIME_HIGH_US + 4 * int'(eff_d2[m]);
				end else if (pwm[m]) begin
					high_len[m]++;
				end else if (pwm_q[m]) begin
					if (high_len[m] != exp_w[m])
						report_error($sformatf("motor %0d high for %0d cycles, expected %0d",
							m + 1, high_len[m], exp_w[m]));
					pulse_count++;
				end
				if (since_rise[m] > 2 * PERIOD) begin
					report_error($sformatf("motor %0d produced no pulse", m + 1));
					since_rise[m] = 0;
				end
			end
			pwm_q = pwm;
			for (int m = 0; m < `NUM_MOTORS; m++) begin
				eff_d2[m] = eff_d1[m];
				eff_d1[m] = (st == ST_ARMED) ? rate_m[m] : '0;
			end
			// Step to the state after the coming rising edge
			if (st == ST_ARMING) begin
				hold_left--;
				if (hold_left == 0)
					st = ST_ARMED;
			end
			if (cmd_valid && cmd_ready) begin
				accept_count++;
				case (cmd_op)
					OP_SET_RATE: begin
						rate_m[cmd_motor] = cmd_rate;
					end
					OP_ARM: begin
						// Ignored when already armed
						if (st == ST_DISARMED) begin
							st        = ST_ARMING;
							hold_left = `ARM_HOLD_CYCLES;
						end
					end
					OP_DISARM: begin
						st = ST_DISARMED;
						for (int m = 0; m < `NUM_MOTORS; m++)
							rate_m[m] = '0;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

/* design/motor_output_top.sv */
/*
 * Motor output stage top
 * Command registers and PWM generator joined by the rate bus
 */
`timescale 1ns/1ps

module motor_output_top
	import motor_pkg::*;
(
	input  logic        us_clk,
	input  logic        resetn,
	// Flight controller command port
	input  logic        cmd_valid,
	output logic        cmd_ready,
	input  motor_op_e   cmd_op,
	input  motor_id_t   cmd_motor,
	input  motor_rate_t cmd_rate,
	// ESC pulse outputs
	output logic        motor_1_pwm,
	output logic        motor_2_pwm,
	output logic        motor_3_pwm,
	output logic        motor_4_pwm
);

	// Effective rates
	motor_rate_if rate_bus ();

	motor_cmd_regs u_cmd_regs (
		.us_clk    (us_clk),
		.resetn    (resetn),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_op    (cmd_op),
		.cmd_motor (cmd_motor),
		.cmd_rate  (cmd_rate),
		.rates     (rate_bus)
	);

	pwm_generator u_pwm_gen (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.rates       (rate_bus),
		.motor_1_pwm (motor_1_pwm),
		.motor_2_pwm (motor_2_pwm),
		.motor_3_pwm (motor_3_pwm),
		.motor_4_pwm (motor_4_pwm)
	);

endmodule

/* design/pwm_generator.sv */
/*
 * Four-channel ESC PWM generator
 * Shared frame timebase, per-frame rate latch, channel instances
 */
`timescale 1ns/1ps
`include "drone_pwm_cfg.svh"

module pwm_generator
	import pwm_pkg::*;
(
	input  logic       us_clk,
	input  logic       resetn,
	motor_rate_if.sink rates,
	output logic       motor_1_pwm,
	output logic       motor_2_pwm,
	output logic       motor_3_pwm,
	output logic       motor_4_pwm
);

	localparam period_count_t PERIOD_LAST = period_count_t'(`PWM_PERIOD_US);
	// Phase flips one count early so it reads MODULATE at count MIN
	localparam period_count_t MOD_START = period_count_t'(`MIN_PWM_TIME_HIGH_US - 1);
	localparam high_count_t   HIGH_MAX  = '1;

	period_count_t          period_counter;
	high_count_t            high_counter;
	pwm_phase_e             phase;
	high_count_t            motor_val [`NUM_MOTORS];
	logic [`NUM_MOTORS-1:0] motor_pwm;
	logic                   period_wrap;

	assign period_wrap = (period_counter == PERIOD_LAST);

	// Frame timebase
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			period_counter <= '0;
			high_counter   <= '0;
			// Outputs stay low until the first wrap
			phase          <= PH_MODULATE;
		end else if (period_wrap) begin
			// New frame
			period_counter <= '0;
			high_counter   <= '0;
			phase          <= PH_MIN_HIGH;
		end else begin
			period_counter <= period_counter + 1'b1;
			if (period_counter == MOD_START)
				phase <= PH_MODULATE;
			// Saturates instead of wrapping back below the compare values
			if (phase == PH_MODULATE && high_counter != HIGH_MAX)
				high_counter <= high_counter + 1'b1;
		end
	end

	// Latch all rates together at the boundary
	// Scaled by four, full rate gives 1020 us of extra high time
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < `NUM_MOTORS; i++)
				motor_val[i] <= '0;
		end else if (period_wrap) begin
			for (int i = 0; i < `NUM_MOTORS; i++)
				motor_val[i] <= {rates.rate[i], 2'b00};
		end
	end

	// One compare block per motor
	for (genvar m = 0; m < `NUM_MOTORS; m++) begin : g_chan
		pwm_generator_block u_block (
			.us_clk         (us_clk),
			.resetn         (resetn),
			.motor_val      (motor_val[m]),
			.period_counter (period_counter),
			.high_counter   (high_counter),
			.phase          (phase),
			.motor_pwm      (motor_pwm[m])
		);
	end

	// Motor numbering starts at 1
	assign motor_1_pwm = motor_pwm[0];
	assign motor_2_pwm = motor_pwm[1];
	assign motor_3_pwm = motor_pwm[2];
	assign motor_4_pwm = motor_pwm[3];

endmodule

/* design/pwm_generator_block.sv */
/*
 * One PWM channel
 * Compares the shared timebase with the latched value
 */
`timescale 1ns/1ps
`include "drone_pwm_cfg.svh"

module pwm_generator_block
	import pwm_pkg::*;
(
	input  logic          us_clk,
	input  logic          resetn,
	input  high_count_t   motor_val,
	input  period_count_t period_counter,
	input  high_count_t   high_counter,
	input  pwm_phase_e    phase,
	output logic          motor_pwm
);

	localparam period_count_t PERIOD_LAST = period_count_t'(`PWM_PERIOD_US);

	logic pwm_next;

	always_comb begin
		// Always low on the last count, pulse never spans a frame edge
		if (period_counter == PERIOD_LAST)
			pwm_next = 1'b0;
		else if (phase == PH_MIN_HIGH)
			pwm_next = 1'b1;
		else
			pwm_next = (high_counter < motor_val);
	end

	// Registered so the pulse is glitch free at the ESC pin
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			motor_pwm <= 1'b0;
		else
			motor_pwm <= pwm_next;
	end

endmodule

/* design/motor_cmd_regs.sv */
/*
 * Command front end and ESC arming guard
 * Arming FSM with zero-throttle hold, four rate registers
 */
`timescale 1ns/1ps
`include "drone_pwm_cfg.svh"

module motor_cmd_regs
	import motor_pkg::*;
(
	input  logic         us_clk,
	input  logic         resetn,
	input  logic         cmd_valid,
	output logic         cmd_ready,
	input  motor_op_e    cmd_op,
	input  motor_id_t    cmd_motor,
	input  motor_rate_t  cmd_rate,
	motor_rate_if.source rates
);

	// Hold counter loads with the last count and runs down to zero
	localparam int HOLD_W = $clog2(`ARM_HOLD_CYCLES);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`ARM_HOLD_CYCLES - 1);

	arm_state_e        state;
	logic [HOLD_W-1:0] hold_cnt;
	motor_rate_t       rate_q [`NUM_MOTORS];
	logic              cmd_fire;

	// Only back-pressure is the arming hold
	assign cmd_ready = (state != ST_ARMING);
	assign cmd_fire  = cmd_valid && cmd_ready;

	// Arming FSM
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state    <= ST_DISARMED;
			hold_cnt <= '0;
		end else begin
			case (state)
				ST_DISARMED: begin
					if (cmd_fire && cmd_op == OP_ARM) begin
						state    <= ST_ARMING;
						hold_cnt <= HOLD_LAST;
					end
				end
				ST_ARMING: begin
					// ESC sees zero throttle for the whole hold
					if (hold_cnt == '0)
						state <= ST_ARMED;
					else
						hold_cnt <= hold_cnt - 1'b1;
				end
				ST_ARMED: begin
					// Repeated ARM is a no-op
					if (cmd_fire && cmd_op == OP_DISARM)
						state <= ST_DISARMED;
				end
				default: begin
					state <= ST_DISARMED;
				end
			endcase
		end
	end

	// Rate registers
	// SET_RATE is stored in any state, DISARM wipes all
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < `NUM_MOTORS; i++)
				rate_q[i] <= '0;
		end else if (cmd_fire) begin
			case (cmd_op)
				OP_SET_RATE: begin
					rate_q[cmd_motor] <= cmd_rate;
				end
				OP_DISARM: begin
					for (int i = 0; i < `NUM_MOTORS; i++)
						rate_q[i] <= '0;
				end
				default: begin
				end
			endcase
		end
	end

	// Stored rates reach the generator only once armed
	always_comb begin
		for (int i = 0; i < `NUM_MOTORS; i++)
			rates.rate[i] = (state == ST_ARMED) ? rate_q[i] : '0;
	end

endmodule

/* design/motor_rate_if.sv */
/*
 * Rate bus from the command registers to the PWM generator
 * Carries the rates in effect, zero while not armed
 */
`timescale 1ns/1ps
`include "drone_pwm_cfg.svh"

interface motor_rate_if
	import motor_pkg::*;
();

	// One rate per motor
	motor_rate_t rate [`NUM_MOTORS];

	// Command registers drive
	modport source (
		output rate
	);

	// Generator samples at the frame boundary
	modport sink (
		input rate
	);

endinterface

/* design/pwm_pkg.sv */
/*
 * PWM timebase types
 * Period count, modulated high count, period phase
 */
package pwm_pkg;

`include "drone_pwm_cfg.svh"

	// Counts us within one frame
	typedef logic [15:0] period_count_t;

	// Counts the modulated part of the pulse
	// Two extra bits since the rate is scaled by four
	typedef logic [`MOTOR_RATE_BIT_WIDTH+1:0] high_count_t;

	// Fixed high part, then the rate dependent part
	typedef enum logic {
		PH_MIN_HIGH = 1'b0,
		PH_MODULATE = 1'b1
	} pwm_phase_e;

endpackage

/* design/motor_pkg.sv */
/*
 * Command side types
 * Motor rate, motor index, command opcode, arming state
 */
package motor_pkg;

`include "drone_pwm_cfg.svh"

	// Unsigned throttle value
	// Zero means idle
	typedef logic [`MOTOR_RATE_BIT_WIDTH-1:0] motor_rate_t;

	// Selects one of the motors
	typedef logic [$clog2(`NUM_MOTORS)-1:0] motor_id_t;

	// Command opcodes from the flight controller
	typedef enum logic [1:0] {
		OP_SET_RATE = 2'd0,
		OP_ARM      = 2'd1,
		OP_DISARM   = 2'd2
	} motor_op_e;

	// Arming guard states
	// ARMING covers the ESC zero-throttle hold
	typedef enum logic [1:0] {
		ST_DISARMED = 2'd0,
		ST_ARMING   = 2'd1,
		ST_ARMED    = 2'd2
	} arm_state_e;

endpackage

/* design/drone_pwm_cfg.svh */
/*
 * Build parameters of the motor output stage
 * Rate width, PWM frame timing, ESC arming hold and motor count
 */
`ifndef DRONE_PWM_CFG_SVH
`define DRONE_PWM_CFG_SVH

// Width of one commanded motor rate
`define MOTOR_RATE_BIT_WIDTH 8

// Last count of the period counter
// One count per us, so the frame is 2.5 ms
`define PWM_PERIOD_US 2499

// Guaranteed high time at the start of every frame
// ESC reads this as zero throttle
`define MIN_PWM_TIME_HIGH_US 1000

// Zero-throttle hold after an arm command, in us_clk cycles
`define ARM_HOLD_CYCLES 64

// Quadcopter
`define NUM_MOTORS 4

`endif
